/* rtl/core_pkg.sv */
// Shared widths, opcode and ALU codes, and pipeline and APB record types for the core
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;

    // RV32I major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_PASS_B = 4'd6;

    //////////////////////////////////////////////////
    // Pipeline records

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_write;
        alu_op_t   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        word_t     branch_offset;
    } issue_packet_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        word_t     addr;
        word_t     wdata;
        reg_addr_t rd;
    } ls_request_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_write;
        word_t     value;
        logic      fault;
    } result_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_write;
        word_t     value;
        logic      fault;
    } retire_trace_t;

    //////////////////////////////////////////////////
    // APB requester side

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } ls_state_t;

endpackage

`default_nettype wire

/* rtl/register_file.sv */
// Integer register file with x0 tied to zero and write-through on a same-cycle read
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Bypass hands over the value being written this cycle
    assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
// Program counter and instruction memory requests, tracking the pc of the word in flight
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output logic  imem_req,
    output word_t imem_addr,
    output logic  fetch_valid,
    output word_t fetch_pc
);

    word_t pc;
    logic  running;

    // No new request while decode cannot take the current word
    assign imem_req  = running && !stall && !redirect;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= RESET_VECTOR;
            running     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                // Outstanding word belongs to the wrong path
                pc          <= redirect_pc;
                fetch_valid <= 1'b0;
            end else if (imem_req) begin
                pc          <= pc + 32'd4;
                fetch_valid <= 1'b1;
                fetch_pc    <= pc;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
// Instruction decode and operand read, registering the packet handed to execute
`timescale 1ns/1ps
`default_nettype none

module decode_unit import core_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetch_valid,
    input  word_t         fetch_pc,
    input  word_t         instruction,
    input  logic          stall,
    input  logic          redirect,
    input  logic          wr_en,
    input  reg_addr_t     wr_addr,
    input  word_t         wr_data,
    output issue_packet_t issue
);

    opcode_t       opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    word_t         rs1_data;
    word_t         rs2_data;
    word_t         imm_i;
    word_t         imm_s;
    word_t         imm_b;
    word_t         imm_u;
    word_t         imm_j;
    logic          writes_rd;
    issue_packet_t next_issue;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // A result from execute lands in the same cycle, so the bypass covers it
    register_file i_register_file (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_addr (instruction[19:15]),
        .rs2_addr (instruction[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // Decode

    always_comb begin
        next_issue            = '0;
        next_issue.valid      = fetch_valid;
        next_issue.pc         = fetch_pc;
        next_issue.alu_op     = ALU_ADD;
        next_issue.operand_a  = rs1_data;
        next_issue.operand_b  = rs2_data;
        next_issue.store_data = rs2_data;
        writes_rd             = 1'b0;
        case (opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: next_issue.alu_op = ALU_ADD;
                    10'b0100000_000: next_issue.alu_op = ALU_SUB;
                    10'b0000000_111: next_issue.alu_op = ALU_AND;
                    10'b0000000_110: next_issue.alu_op = ALU_OR;
                    10'b0000000_100: next_issue.alu_op = ALU_XOR;
                    10'b0000000_010: next_issue.alu_op = ALU_SLT;
                    default:         writes_rd = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                writes_rd            = 1'b1;
                next_issue.operand_b = imm_i;
                case (funct3)
                    3'b000:  next_issue.alu_op = ALU_ADD;
                    3'b111:  next_issue.alu_op = ALU_AND;
                    3'b110:  next_issue.alu_op = ALU_OR;
                    3'b100:  next_issue.alu_op = ALU_XOR;
                    default: writes_rd = 1'b0;
                endcase
            end
            OPC_LUI: begin
                writes_rd            = 1'b1;
                next_issue.alu_op    = ALU_PASS_B;
                next_issue.operand_b = imm_u;
            end
            OPC_LOAD: begin
                // Word loads only
                writes_rd            = (funct3 == 3'b010);
                next_issue.is_load   = (funct3 == 3'b010);
                next_issue.operand_b = imm_i;
            end
            OPC_STORE: begin
                next_issue.is_store  = (funct3 == 3'b010);
                next_issue.operand_b = imm_s;
            end
            OPC_BRANCH: begin
                next_issue.is_branch     = (funct3[2:1] == 2'b00);
                next_issue.branch_ne     = funct3[0];
                next_issue.branch_offset = imm_b;
            end
            OPC_JAL: begin
                writes_rd                = 1'b1;
                next_issue.is_jal        = 1'b1;
                next_issue.branch_offset = imm_j;
            end
            default: writes_rd = 1'b0;
        endcase
        next_issue.rd       = writes_rd ? instruction[11:7] : 5'd0;
        next_issue.rd_write = writes_rd && (instruction[11:7] != 5'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (redirect) begin
            issue.valid <= 1'b0;
        end else if (!stall) begin
            issue <= next_issue;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
// ALU, branch resolution and hand-off of loads and stores to the APB unit
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  issue_packet_t issue,
    input  logic          ls_done,
    output logic          stall,
    output logic          redirect,
    output word_t         redirect_pc,
    output ls_request_t   ls_request,
    output result_t       alu_result
);

    word_t alu_out;
    logic  is_mem;
    logic  operands_equal;
    logic  branch_taken;
    logic  mem_busy;

    always_comb begin
        case (issue.alu_op)
            ALU_SUB:    alu_out = issue.operand_a - issue.operand_b;
            ALU_AND:    alu_out = issue.operand_a & issue.operand_b;
            ALU_OR:     alu_out = issue.operand_a | issue.operand_b;
            ALU_XOR:    alu_out = issue.operand_a ^ issue.operand_b;
            ALU_SLT:    alu_out = {31'b0, $signed(issue.operand_a) < $signed(issue.operand_b)};
            ALU_PASS_B: alu_out = issue.operand_b;
            default:    alu_out = issue.operand_a + issue.operand_b;
        endcase
    end

    //////////////////////////////////////////////////
    // Branches and jumps

    assign operands_equal = (issue.operand_a == issue.operand_b);
    assign branch_taken   = issue.is_branch && (issue.branch_ne ^ operands_equal);
    assign redirect       = issue.valid && (branch_taken || issue.is_jal);
    assign redirect_pc    = issue.pc + issue.branch_offset;

    // Pc goes out every cycle, it also tags a finishing memory op
    assign alu_result.valid    = issue.valid && !is_mem;
    assign alu_result.pc       = issue.pc;
    assign alu_result.rd       = issue.rd;
    assign alu_result.rd_write = issue.rd_write;
    assign alu_result.value    = issue.is_jal ? issue.pc + 32'd4 : alu_out;
    assign alu_result.fault    = 1'b0;

    //////////////////////////////////////////////////
    // Memory operations

    assign is_mem = issue.is_load || issue.is_store;

    // Request goes out once, then the packet waits here for completion
    assign ls_request.valid = issue.valid && is_mem && !mem_busy;
    assign ls_request.write = issue.is_store;
    assign ls_request.addr  = alu_out;
    assign ls_request.wdata = issue.store_data;
    assign ls_request.rd    = issue.rd;

    assign stall = issue.valid && is_mem && !ls_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
        end else if (ls_done) begin
            mem_busy <= 1'b0;
        end else if (ls_request.valid) begin
            mem_busy <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_load_store.sv */
// APB requester carrying word loads and stores, returning one result per transfer
`timescale 1ns/1ps
`default_nettype none

module apb_load_store import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  ls_request_t ls_request,
    output apb_req_t    apb,
    input  apb_rsp_t    apb_resp,
    output logic        ls_done,
    output result_t     ls_result
);

    ls_state_t state;
    reg_addr_t rd;

    assign apb.psel    = (state != IDLE);
    assign apb.penable = (state == ACCESS);

    //////////////////////////////////////////////////
    // Transfer FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (ls_request.valid) state <= SETUP;
                SETUP:   state <= ACCESS;
                ACCESS:  if (apb_resp.pready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Address phase values stay put until the next request
    always_ff @(posedge clk) begin
        if (state == IDLE && ls_request.valid) begin
            apb.pwrite <= ls_request.write;
            apb.paddr  <= ls_request.addr;
            apb.pwdata <= ls_request.wdata;
            rd         <= ls_request.rd;
        end
    end

    //////////////////////////////////////////////////
    // Completion record

    always_ff @(posedge clk) begin
        if (reset) begin
            ls_result.valid <= 1'b0;
        end else if (state == ACCESS && apb_resp.pready) begin
            ls_result.valid    <= 1'b1;
            ls_result.pc       <= '0;
            ls_result.rd       <= rd;
            // Error response leaves the destination untouched
            ls_result.rd_write <= !apb.pwrite && !apb_resp.pslverr && (rd != 5'd0);
            ls_result.value    <= apb.pwrite ? '0 : apb_resp.prdata;
            ls_result.fault    <= apb_resp.pslverr;
        end else begin
            ls_result.valid <= 1'b0;
        end
    end

    assign ls_done = ls_result.valid;

endmodule

`default_nettype wire

/* rtl/result_unit.sv */
// Writeback selection and the registered retire trace
`timescale 1ns/1ps
`default_nettype none

module result_unit import core_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  result_t       alu_result,
    input  result_t       ls_result,
    output logic          wr_en,
    output reg_addr_t     wr_addr,
    output word_t         wr_data,
    output retire_trace_t trace
);

    result_t selected;

    // Execute only reports a valid result when no memory op is finishing
    assign selected = ls_result.valid ? ls_result : alu_result;

    assign wr_en   = selected.valid && selected.rd_write;
    assign wr_addr = selected.rd;
    assign wr_data = selected.value;

    always_ff @(posedge clk) begin
        if (reset) begin
            trace.valid <= 1'b0;
        end else begin
            trace.valid    <= selected.valid;
            // Execute still holds the memory op while its result returns
            trace.pc       <= alu_result.pc;
            trace.rd       <= selected.rd;
            trace.rd_write <= selected.rd_write;
            trace.value    <= selected.value;
            trace.fault    <= selected.fault;
        end
    end

endmodule

`default_nettype wire

/* rtl/mini_core.sv */
// Top level of the three-stage RV32I core, wiring fetch, decode, execute and memory units
`timescale 1ns/1ps
`default_nettype none

module mini_core import core_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          reset,
    output logic          imem_req,
    output word_t         imem_addr,
    input  word_t         imem_data,
    output apb_req_t      apb,
    input  apb_rsp_t      apb_resp,
    output retire_trace_t trace
);

    logic          fetch_valid;
    word_t         fetch_pc;
    logic          stall;
    logic          redirect;
    word_t         redirect_pc;
    issue_packet_t issue;
    ls_request_t   ls_request;
    logic          ls_done;
    result_t       ls_result;
    result_t       alu_result;
    logic          wr_en;
    reg_addr_t     wr_addr;
    word_t         wr_data;

    //////////////////////////////////////////////////
    // Front end

    fetch_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_fetch_unit (
        .*
    );

    decode_unit i_decode_unit (
        .*,
        .instruction (imem_data)
    );

    //////////////////////////////////////////////////
    // Execute, memory and writeback

    execute_unit i_execute_unit (.*);

    apb_load_store i_apb_load_store (.*);

    result_unit i_result_unit (.*);

endmodule

`default_nettype wire

/* verif/core_asserts.sv */
// APB protocol and trace rules for the core, bound to every mini_core instance
`timescale 1ns/1ps
`default_nettype none

module core_asserts import core_pkg::*; (
    input logic          clk,
    input logic          reset,
    input apb_req_t      apb,
    input apb_rsp_t      apb_resp,
    input retire_trace_t trace
);

    // SETUP lasts exactly one cycle
    setup_then_access: assert property (
        @(posedge clk) disable iff (reset)
        apb.psel && !apb.penable |=> apb.psel && apb.penable
    ) else $error("APB setup phase not followed by an access phase");

    // Transfer held while the completer inserts wait states
    stable_while_waiting: assert property (
        @(posedge clk) disable iff (reset)
        apb.psel && apb.penable && !apb_resp.pready |=>
            apb.psel && apb.penable && $stable(apb.paddr) &&
            $stable(apb.pwrite) && $stable(apb.pwdata)
    ) else $error("APB access phase changed before pready");

    no_trace_in_reset: assert property (
        @(posedge clk) reset |=> !trace.valid
    ) else $error("trace.valid high while the core is held in reset");

endmodule

bind mini_core core_asserts i_core_asserts (
    .clk      (clk),
    .reset    (reset),
    .apb      (apb),
    .apb_resp (apb_resp),
    .trace    (trace)
);

`default_nettype wire

/* verif/core_tb.sv */
// Random-program testbench for mini_core with a reference ISA model, APB memory and trace checks
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam word_t      RESET_VECTOR = 32'h0000_0200;
    localparam int         NUM_PROGRAMS = 8;
    localparam int         PROGRAM_LEN  = 200;
    localparam int         RESET_CYCLES = 16;
    localparam int         MAX_CYCLES   = NUM_PROGRAMS * (PROGRAM_LEN * 8 + RESET_CYCLES);
    localparam word_t      LOOP_PC      = RESET_VECTOR + 32'((PROGRAM_LEN - 1) * 4);
    localparam logic [7:0] ERROR_WORD   = 8'd252;

    logic          clk = 1'b0;
    logic          reset;
    logic          imem_req;
    word_t         imem_addr;
    word_t         imem_data;
    apb_req_t      apb;
    apb_rsp_t      apb_resp;
    retire_trace_t trace;

    int    seed = 45250;
    int    cycle_count = 0;
    int    wait_states = 0;
    logic  fetch_pending = 1'b0;
    word_t fetch_addr;
    logic  program_done;
    word_t prog [PROGRAM_LEN];
    word_t apb_mem [256];
    word_t model_mem [256];
    word_t model_regs [32];
    word_t model_pc;

    mini_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_mini_core (
        .clk       (clk),
        .reset     (reset),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .apb       (apb),
        .apb_resp  (apb_resp),
        .trace     (trace)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Failure reporting and timeout

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_field(string name, word_t expected, word_t actual);
        assert (actual === expected) else
            report_failure($sformatf("error: %s expected %h actual %h", name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles with programs unfinished",
                                     cycle_count));
        end
    end

    //////////////////////////////////////////////////
    // Instruction encoders

    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    // Word store with x0 as base
    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    //////////////////////////////////////////////////
    // Program and memory setup

    task automatic load_program();
        int          kind;
        int          step;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        logic [7:0]  word;
        for (int i = 0; i < PROGRAM_LEN; i++) begin
            rd   = 5'($random(seed) & 15);
            rs1  = 5'($random(seed) & 15);
            rs2  = 5'($random(seed) & 15);
            kind = $random(seed) & 15;
            imm  = 12'($random(seed));
            word = (($random(seed) & 3) == 0) ? ERROR_WORD : 8'($random(seed));
            step = 1 + ($random(seed) & 3);
            if (i + step > PROGRAM_LEN - 1) begin
                step = PROGRAM_LEN - 1 - i;
            end
            // Opening block gives x1 to x15 a known value
            if (i < 15) begin
                prog[i] = i_type(imm, 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
            end else if (i == PROGRAM_LEN - 1) begin
                prog[i] = j_type(21'd0, 5'd0);
            end else begin
                case (kind)
                    0:  prog[i] = r_type(7'h00, rs2, rs1, 3'b000, rd);
                    1:  prog[i] = r_type(7'h20, rs2, rs1, 3'b000, rd);
                    2:  prog[i] = r_type(7'h00, rs2, rs1, 3'b111, rd);
                    3:  prog[i] = r_type(7'h00, rs2, rs1, 3'b110, rd);
                    4:  prog[i] = r_type(7'h00, rs2, rs1, 3'b100, rd);
                    5:  prog[i] = r_type(7'h00, rs2, rs1, 3'b010, rd);
                    6:  prog[i] = i_type(imm, rs1, 3'b000, rd, 7'b0010011);
                    7:  prog[i] = i_type(imm, rs1, 3'b111, rd, 7'b0010011);
                    8:  prog[i] = i_type(imm, rs1, 3'b110, rd, 7'b0010011);
                    9:  prog[i] = i_type(imm, rs1, 3'b100, rd, 7'b0010011);
                    10: prog[i] = {20'($random(seed)), rd, 7'b0110111};
                    11: prog[i] = i_type({2'b00, word, 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
                    12: prog[i] = s_type({2'b00, word, 2'b00}, rs2);
                    13: prog[i] = b_type(13'(step * 4), rs2, rs1, 3'b000);
                    14: prog[i] = b_type(13'(step * 4), rs2, rs1, 3'b001);
                    default: prog[i] = j_type(21'(step * 4), rd);
                endcase
            end
        end
        for (int i = 0; i < 256; i++) begin
            apb_mem[i]   = $random(seed);
            model_mem[i] = apb_mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc     = RESET_VECTOR;
        program_done = 1'b0;
    endtask

    task automatic start_program();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        load_program();
        check_field("trace.valid", '0, trace.valid);
        check_field("apb.psel", '0, apb.psel);
        check_field("apb.penable", '0, apb.penable);
        check_field("imem_req", '0, imem_req);
        repeat (RESET_CYCLES - 2) @(negedge clk);
        reset = 1'b0;
        while (!imem_req) begin
            @(negedge clk);
        end
        check_field("imem_addr", RESET_VECTOR, imem_addr);
    endtask

    //////////////////////////////////////////////////
    // Instruction memory and APB completer

    always @(negedge clk) begin
        if (fetch_pending) begin
            imem_data = ((fetch_addr - RESET_VECTOR) >> 2 < PROGRAM_LEN) ?
                        prog[(fetch_addr - RESET_VECTOR) >> 2] : 32'h0000_0013;
        end
        fetch_pending = imem_req;
        fetch_addr    = imem_addr;
    end

    always @(negedge clk) begin
        apb_resp.pready  = 1'b0;
        apb_resp.pslverr = 1'b0;
        if (apb.psel && !apb.penable) begin
            wait_states = $random(seed) & 3;
        end else if (apb.psel && apb.penable) begin
            if (wait_states > 0) begin
                wait_states = wait_states - 1;
            end else begin
                apb_resp.pready = 1'b1;
                if (apb.paddr[9:2] == ERROR_WORD) begin
                    apb_resp.pslverr = 1'b1;
                end else if (apb.pwrite) begin
                    apb_mem[apb.paddr[9:2]] = apb.pwdata;
                end else begin
                    apb_resp.prdata = apb_mem[apb.paddr[9:2]];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Reference model, one step per retired record

    task automatic retire_next();
        word_t w;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t addr;
        word_t value;
        word_t next_pc;
        logic  wr;
        logic  fault;
        w       = prog[(model_pc - RESET_VECTOR) >> 2];
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        next_pc = model_pc + 32'd4;
        value   = '0;
        wr      = 1'b0;
        fault   = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                wr = 1'b1;
                case ({w[30], w[14:12]})
                    4'b0000: value = a + b;
                    4'b1000: value = a - b;
                    4'b0111: value = a & b;
                    4'b0110: value = a | b;
                    4'b0100: value = a ^ b;
                    default: value = {31'b0, $signed(a) < $signed(b)};
                endcase
            end
            7'b0010011: begin
                wr = 1'b1;
                case (w[14:12])
                    3'b000:  value = a + imm_i;
                    3'b111:  value = a & imm_i;
                    3'b110:  value = a | imm_i;
                    default: value = a ^ imm_i;
                endcase
            end
            7'b0110111: begin
                wr    = 1'b1;
                value = {w[31:12], 12'b0};
            end
            7'b0000011: begin
                addr  = a + imm_i;
                fault = (addr[9:2] == ERROR_WORD);
                wr    = !fault;
                value = model_mem[addr[9:2]];
            end
            7'b0100011: begin
                addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};
                fault = (addr[9:2] == ERROR_WORD);
                if (!fault) begin
                    model_mem[addr[9:2]] = b;
                end
            end
            7'b1100011: begin
                if ((a == b) != w[12]) begin
                    next_pc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                wr      = 1'b1;
                value   = model_pc + 32'd4;
                next_pc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (w[11:7] == 5'd0) begin
            wr = 1'b0;
        end
        check_field("trace.pc", model_pc, trace.pc);
        check_field("trace.rd_write", wr, trace.rd_write);
        check_field("trace.fault", fault, trace.fault);
        if (wr) begin
            check_field("trace.rd", w[11:7], trace.rd);
            check_field("trace.value", value, trace.value);
            model_regs[w[11:7]] = value;
        end
        if (model_pc == LOOP_PC) begin
            program_done = 1'b1;
        end
        model_pc = next_pc;
    endtask

    always @(negedge clk) begin
        if (trace.valid) begin
            retire_next();
        end
    end

    initial begin
        reset     = 1'b1;
        imem_data = '0;
        apb_resp  = '0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            start_program();
            while (!program_done) begin
                @(negedge clk);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/core_pkg.sv
rtl/register_file.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/apb_load_store.sv
rtl/result_unit.sv
rtl/mini_core.sv
verif/core_asserts.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: mini_core

sources:
  # Core RTL in compile order
  - files:
      - rtl/core_pkg.sv
      - rtl/register_file.sv
      - rtl/fetch_unit.sv
      - rtl/decode_unit.sv
      - rtl/execute_unit.sv
      - rtl/apb_load_store.sv
      - rtl/result_unit.sv
      - rtl/mini_core.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/core_asserts.sv
      - verif/core_tb.sv
